// ==== verilog/fp_add_pkg.sv ====
// format constants, operation codes and the word decode shared by the
// double-precision adder; each design file imports what it needs

package fp_add_pkg;

    //////////////////////////////
    // binary64 layout
    //////////////////////////////
    localparam int DATA_W = 64;
    localparam int EXP_W  = 11;
    localparam int FRAC_W = 52;
    // fraction with the hidden bit in front
    localparam int MANT_W = FRAC_W + 1;
    // two headroom bits, mantissa, then room for shifted-out bits
    localparam int ADDER_W = 2 * FRAC_W + 3;

    // all-ones exponent marks infinity
    localparam logic [EXP_W-1:0] EXP_MAX = '1;

    //////////////////////////////
    // mantissa operation codes
    //////////////////////////////
    // picked from the sign pair of the operands
    localparam logic [1:0] OP_A_SUB_B = 2'd1;
    localparam logic [1:0] OP_B_SUB_A = 2'd2;
    localparam logic [1:0] OP_ADD     = 2'd3;

    //////////////////////////////
    // operand word
    //////////////////////////////
    // one 64-bit word seen as raw bits or as its three fields
    typedef union packed {
        logic [DATA_W-1:0] bits;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exp;
            logic [FRAC_W-1:0] frac;
        } fields;
    } fp_word_u;

endpackage

// ==== verilog/fp_stage_if.sv ====
`timescale 1ns/1ps
// stage boundary bundles of the adder pipeline
// align to add/sub, and normalize to round

// aligned mantissas and the larger exponent from stage 2 to stage 3
interface fp_align_if;
    import fp_add_pkg::*;

    logic [ADDER_W-1:0] frac_a;
    logic [ADDER_W-1:0] frac_b;
    logic [EXP_W-1:0]   exp;

    // aligner side
    modport src (output frac_a, output frac_b, output exp);
    // add/sub side
    modport dst (input frac_a, input frac_b, input exp);
endinterface

// normalized fraction with rounding bits from stage 4 to stage 5
interface fp_norm_if;
    import fp_add_pkg::*;

    logic [FRAC_W-1:0] frac;
    logic [EXP_W-1:0]  exp;
    logic              guard_bit;
    logic              round_bit;
    logic              sticky_bit;

    // lsb is frac[0] and not carried on its own
    modport src (output frac, output exp, output guard_bit, output round_bit,
                 output sticky_bit);
    modport dst (input frac, input exp, input guard_bit, input round_bit,
                 input sticky_bit);
endinterface

// ==== verilog/fp_add_ctrl.sv ====
`timescale 1ns/1ps
// pipeline control of the adder with the valid chain, operation decode
// and sign and infinity tracking up to the result sign

module fp_add_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       sign_a,
    input  logic       sign_b,
    input  logic       inf_a,
    input  logic       inf_b,
    input  logic       frac_sign,
    output logic [1:0] op,
    output logic       inf_case,
    output logic       result_sign,
    output logic       out_valid
);
    import fp_add_pkg::*;

    // valid of stages 1 to 5 with stage 1 in the lsb
    logic [4:0] valid_q;
    // {a, b} pairs at stages 2 and 3
    logic [1:0] sign_q2;
    logic [1:0] sign_q3;
    logic [1:0] inf_q2;
    logic [1:0] inf_q3;
    logic       sign_q4;
    logic [1:0] op_next;
    logic       sign_sel;

    // equal signs add and otherwise the negative operand is subtracted
    always_comb begin
        if (sign_a == sign_b) begin
            op_next = OP_ADD;
        end else if (sign_b) begin
            op_next = OP_A_SUB_B;
        end else begin
            op_next = OP_B_SUB_A;
        end
    end

    // stage 3 sign pick
    always_comb begin
        if (inf_q3[1]) begin
            sign_sel = sign_q3[1];
        end else if (inf_q3[0]) begin
            sign_sel = sign_q3[0];
        end else if (sign_q3[1] == sign_q3[0]) begin
            sign_sel = sign_q3[1];
        end else begin
            // mixed signs take the sign of the mantissa difference
            sign_sel = frac_sign;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= '0;
            op          <= OP_ADD;
            sign_q2     <= '0;
            sign_q3     <= '0;
            inf_q2      <= '0;
            inf_q3      <= '0;
            sign_q4     <= 1'b0;
            inf_case    <= 1'b0;
            result_sign <= 1'b0;
        end else begin
            valid_q     <= {valid_q[3:0], in_valid};
            op          <= op_next;
            sign_q2     <= {sign_a, sign_b};
            sign_q3     <= sign_q2;
            inf_q2      <= {inf_a, inf_b};
            inf_q3      <= inf_q2;
            sign_q4     <= sign_sel;
            inf_case    <= |inf_q3;
            result_sign <= sign_q4;
        end
    end

    assign out_valid = valid_q[4];

    // the strobe seen by the consumer is always a clean level
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid));

endmodule

// ==== verilog/fp_align.sv ====
`timescale 1ns/1ps
// stages 1 and 2 unpack both operands, compare exponents and shift the
// smaller mantissa right while folding every lost bit into bit 0

module fp_align (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [fp_add_pkg::DATA_W-1:0] in_a,
    input  logic [fp_add_pkg::DATA_W-1:0] in_b,
    output logic                          sign_a,
    output logic                          sign_b,
    output logic                          inf_a,
    output logic                          inf_b,
    fp_align_if.src                       algn
);
    import fp_add_pkg::*;

    fp_word_u           word_a;
    fp_word_u           word_b;
    logic [EXP_W-1:0]   eff_exp_a;
    logic [EXP_W-1:0]   eff_exp_b;
    logic               nan_a;
    logic               nan_b;
    // stage 1 registers
    logic [MANT_W-1:0]  mant_a1;
    logic [MANT_W-1:0]  mant_b1;
    logic [EXP_W-1:0]   exp_a1;
    logic [EXP_W-1:0]   exp_b1;
    logic [EXP_W-1:0]   diff_ab1;
    logic [EXP_W-1:0]   diff_ba1;
    logic               a_ge_b1;
    // stage 2 datapath
    logic [ADDER_W-1:0] wide_a;
    logic [ADDER_W-1:0] wide_b;
    logic [EXP_W-1:0]   diff;

    // right shift with the shifted-out bits ORed into the lsb
    function automatic logic [ADDER_W-1:0] shift_jam(
        input logic [ADDER_W-1:0] v,
        input logic [EXP_W-1:0]   amt
    );
        logic [ADDER_W-1:0] lost_mask;
        logic [ADDER_W-1:0] shifted;
        // shifts past the word width give an all-ones mask
        lost_mask  = ~({ADDER_W{1'b1}} << amt);
        shifted    = v >> amt;
        shifted[0] = shifted[0] | (|(v & lost_mask));
        return shifted;
    endfunction

    assign word_a = in_a;
    assign word_b = in_b;

    // subnormals sit at an effective exponent of 1
    assign eff_exp_a = (word_a.fields.exp == '0) ? EXP_W'(1) : word_a.fields.exp;
    assign eff_exp_b = (word_b.fields.exp == '0) ? EXP_W'(1) : word_b.fields.exp;

    assign nan_a = (word_a.fields.exp == EXP_MAX) && (word_a.fields.frac != '0);
    assign nan_b = (word_b.fields.exp == EXP_MAX) && (word_b.fields.frac != '0);

    //////////////////////////////
    // stage 1
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mant_a1  <= '0;
            mant_b1  <= '0;
            exp_a1   <= '0;
            exp_b1   <= '0;
            diff_ab1 <= '0;
            diff_ba1 <= '0;
            a_ge_b1  <= 1'b0;
            sign_a   <= 1'b0;
            sign_b   <= 1'b0;
            inf_a    <= 1'b0;
            inf_b    <= 1'b0;
        end else if (in_valid) begin
            // hidden bit set by any nonzero exponent
            mant_a1  <= {|word_a.fields.exp, word_a.fields.frac};
            mant_b1  <= {|word_b.fields.exp, word_b.fields.frac};
            exp_a1   <= eff_exp_a;
            exp_b1   <= eff_exp_b;
            diff_ab1 <= eff_exp_a - eff_exp_b;
            diff_ba1 <= eff_exp_b - eff_exp_a;
            a_ge_b1  <= eff_exp_a >= eff_exp_b;
            sign_a   <= word_a.fields.sign;
            sign_b   <= word_b.fields.sign;
            inf_a    <= word_a.fields.exp == EXP_MAX;
            inf_b    <= word_b.fields.exp == EXP_MAX;
        end
    end

    //////////////////////////////
    // stage 2
    //////////////////////////////
    // 00 | hidden + fraction | zero low bits
    assign wide_a = {2'b00, mant_a1, {FRAC_W{1'b0}}};
    assign wide_b = {2'b00, mant_b1, {FRAC_W{1'b0}}};
    assign diff   = a_ge_b1 ? diff_ab1 : diff_ba1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            algn.frac_a <= '0;
            algn.frac_b <= '0;
            algn.exp    <= '0;
        end else begin
            algn.frac_a <= a_ge_b1 ? wide_a : shift_jam(wide_a, diff);
            algn.frac_b <= a_ge_b1 ? shift_jam(wide_b, diff) : wide_b;
            algn.exp    <= a_ge_b1 ? exp_a1 : exp_b1;
        end
    end

    // NaN operands are screened upstream of the adder
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !(nan_a || nan_b));

endmodule

// ==== verilog/fp_mant_addsub.sv ====
`timescale 1ns/1ps
// stage 3 does the two's-complement add or subtract of the aligned mantissas
// and the top headroom bit of the registered sum is its sign

module fp_mant_addsub (
    input  logic                                  clk,
    input  logic                                  rst_n,
    fp_align_if.dst                               algn,
    input  logic [1:0]                            op,
    output logic signed [fp_add_pkg::ADDER_W-1:0] sum,
    output logic [fp_add_pkg::EXP_W-1:0]          exp
);
    import fp_add_pkg::*;

    logic [ADDER_W-1:0] sum_next;

    always_comb begin
        case (op)
            OP_A_SUB_B: sum_next = algn.frac_a - algn.frac_b;
            OP_B_SUB_A: sum_next = algn.frac_b - algn.frac_a;
            // equal signs add the magnitudes
            default:    sum_next = algn.frac_a + algn.frac_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
            exp <= '0;
        end else begin
            sum <= signed'(sum_next);
            exp <= algn.exp;
        end
    end

endmodule

// ==== verilog/fp_normalize.sv ====
`timescale 1ns/1ps
// stage 4 takes the magnitude of the signed sum, counts leading zeros and
// shifts to normalize, then picks guard, round and sticky below the fraction

module fp_normalize (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic signed [fp_add_pkg::ADDER_W-1:0] sum,
    input  logic [fp_add_pkg::EXP_W-1:0]          exp,
    output logic                                  frac_sign,
    fp_norm_if.src                                norm
);
    import fp_add_pkg::*;

    // carry and hidden bit positions in the working word
    localparam int CARRY_BIT = ADDER_W - 2;
    localparam int HID_BIT   = ADDER_W - 3;
    localparam int GUARD_BIT = HID_BIT - FRAC_W - 1;

    logic [ADDER_W-1:0] abs_v;
    logic [ADDER_W-1:0] norm_v;
    logic [EXP_W-1:0]   lz;
    logic [EXP_W-1:0]   shamt;
    logic [EXP_W-1:0]   exp_n;
    logic               lost;
    logic               is_zero;

    assign frac_sign = sum[ADDER_W-1];
    assign abs_v     = frac_sign ? -sum : sum;
    assign is_zero   = (abs_v == '0);

    // zeros above the leading one counted from the hidden bit down
    always_comb begin
        lz = EXP_W'(HID_BIT + 1);
        for (int i = 0; i <= HID_BIT; i++) begin
            // highest set bit is the last to write
            if (abs_v[i]) begin
                lz = EXP_W'(HID_BIT - i);
            end
        end
    end

    // stop at the subnormal floor of effective exponent 1
    assign shamt = (lz < exp) ? lz : exp - 1'b1;

    always_comb begin
        lost   = 1'b0;
        norm_v = abs_v << shamt;
        exp_n  = exp - lz;
        if (abs_v[CARRY_BIT]) begin
            // carry out of the mantissa moves one step right
            norm_v = abs_v >> 1;
            lost   = abs_v[0];
            exp_n  = exp + 1'b1;
        end else if (is_zero || lz >= exp) begin
            // zero or subnormal result
            exp_n = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm.frac       <= '0;
            norm.exp        <= '0;
            norm.guard_bit  <= 1'b0;
            norm.round_bit  <= 1'b0;
            norm.sticky_bit <= 1'b0;
        end else begin
            norm.frac       <= norm_v[HID_BIT-1 -: FRAC_W];
            norm.exp        <= exp_n;
            norm.guard_bit  <= norm_v[GUARD_BIT];
            norm.round_bit  <= norm_v[GUARD_BIT-1];
            norm.sticky_bit <= (|norm_v[GUARD_BIT-2:0]) | lost;
        end
    end

endmodule

// ==== verilog/fp_round.sv ====
`timescale 1ns/1ps
// stage 5 rounds to nearest even, renormalizes a rounding carry and
// forces infinity when an operand was infinite

module fp_round (
    input  logic                          clk,
    input  logic                          rst_n,
    fp_norm_if.dst                        norm,
    input  logic                          inf_case,
    output logic [fp_add_pkg::EXP_W-1:0]  exp_out,
    output logic [fp_add_pkg::FRAC_W-1:0] frac_out
);
    import fp_add_pkg::*;

    // carry | hidden | fraction
    logic [MANT_W:0] mant_r;
    logic            hidden;
    logic            round_up;

    assign hidden = (norm.exp != '0);

    // ties go to the even neighbour
    assign round_up = norm.guard_bit & (norm.round_bit | norm.sticky_bit | norm.frac[0]);
    assign mant_r   = {1'b0, hidden, norm.frac} + {{MANT_W{1'b0}}, round_up};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_out  <= '0;
            frac_out <= '0;
        end else if (inf_case) begin
            exp_out  <= EXP_MAX;
            frac_out <= '0;
        end else if (mant_r[MANT_W]) begin
            // 1.11..1 rounded up moves one place right
            exp_out  <= norm.exp + 1'b1;
            frac_out <= mant_r[FRAC_W:1];
        end else if (!hidden && mant_r[FRAC_W]) begin
            // subnormal rounded up into the smallest normal
            exp_out  <= EXP_W'(1);
            frac_out <= mant_r[FRAC_W-1:0];
        end else begin
            exp_out  <= norm.exp;
            frac_out <= mant_r[FRAC_W-1:0];
        end
    end

    // with finite exponents kept below 0x7FE the result never encodes a NaN
    assert property (@(posedge clk) disable iff (!rst_n)
        (exp_out == EXP_MAX) |-> (frac_out == '0));

endmodule

// ==== verilog/fp_add_top.sv ====
`timescale 1ns/1ps
// five-stage IEEE 754 double adder; a pair taken on in_valid comes back
// rounded on out_valid five cycles later, one pair per cycle

module fp_add_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [fp_add_pkg::DATA_W-1:0] in_a,
    input  logic [fp_add_pkg::DATA_W-1:0] in_b,
    output logic [fp_add_pkg::DATA_W-1:0] result,
    output logic                          out_valid
);
    import fp_add_pkg::*;

    logic                      sign_a;
    logic                      sign_b;
    logic                      inf_a;
    logic                      inf_b;
    logic [1:0]                op;
    logic signed [ADDER_W-1:0] sum;
    logic [EXP_W-1:0]          sum_exp;
    logic                      frac_sign;
    logic                      inf_case;
    logic                      result_sign;
    logic [EXP_W-1:0]          exp_out;
    logic [FRAC_W-1:0]         frac_out;
    fp_word_u                  res_w;

    fp_align_if algn_if ();
    fp_norm_if  norm_if ();

    fp_add_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .sign_a(sign_a), .sign_b(sign_b), .inf_a(inf_a), .inf_b(inf_b),
        .frac_sign(frac_sign), .op(op), .inf_case(inf_case),
        .result_sign(result_sign), .out_valid(out_valid)
    );

    fp_align align_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_a(in_a), .in_b(in_b),
        .sign_a(sign_a), .sign_b(sign_b), .inf_a(inf_a), .inf_b(inf_b),
        .algn(algn_if.src)
    );

    fp_mant_addsub addsub_i (
        .clk(clk), .rst_n(rst_n), .algn(algn_if.dst), .op(op),
        .sum(sum), .exp(sum_exp)
    );

    fp_normalize norm_i (
        .clk(clk), .rst_n(rst_n), .sum(sum), .exp(sum_exp),
        .frac_sign(frac_sign), .norm(norm_if.src)
    );

    fp_round round_i (
        .clk(clk), .rst_n(rst_n), .norm(norm_if.dst), .inf_case(inf_case),
        .exp_out(exp_out), .frac_out(frac_out)
    );

    // sign from control, exponent and fraction from the rounder
    assign res_w.fields = '{sign: result_sign, exp: exp_out, frac: frac_out};
    assign result       = res_w.bits;

endmodule

// ==== verification/fp_add_tb.sv ====
`timescale 1ns/1ps
// self-checking testbench of the double adder that sends random operand pairs
// and compares results, latency and order against a real-arithmetic model

module fp_add_tb;

    localparam int LATENCY     = 5;
    localparam int NUM_PAIRS   = 3000;
    localparam int DRAIN_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [63:0] in_a;
    logic [63:0] in_b;
    logic [63:0] result;
    logic        out_valid;

    // pairs in flight, oldest first
    logic [63:0] want_q[$];
    logic [63:0] opa_q[$];
    logic [63:0] opb_q[$];
    int unsigned sent_q[$];

    int unsigned cycle;
    int          err_value;
    int          err_timing;
    int          err_missing;
    int          sent;
    int          wait_cnt;
    logic [63:0] pair_a;
    logic [63:0] pair_b;

    fp_add_top dut_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_a(in_a), .in_b(in_b),
        .result(result), .out_valid(out_valid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////
    // operand generation
    //////////////////////////////
    function automatic logic [51:0] rand_frac();
        logic [63:0] w;
        w = {$urandom, $urandom};
        return w[51:0];
    endfunction

    // finite normal with exponent 1 to 0x7FD so no sum overflows
    function automatic logic [63:0] rand_normal();
        logic [10:0] e;
        e = 11'(1 + $urandom % 32'h7FD);
        return {1'($urandom), e, rand_frac()};
    endfunction

    // exponent 0, 1 or 2 for subnormals and the bottom of the normal range
    function automatic logic [63:0] rand_small();
        logic [10:0] e;
        e = 11'($urandom % 3);
        return {1'($urandom), e, rand_frac()};
    endfunction

    task automatic make_pair(output logic [63:0] a, output logic [63:0] b);
        int unsigned mode;
        logic [10:0] ea;
        logic [10:0] eb;
        logic [63:0] tmp;
        mode = $urandom % 16;
        a    = rand_normal();
        b    = rand_normal();
        case (mode)
            // exact negation must give +0
            7, 8: b = {~a[63], a[62:0]};
            // near negation gives a long left shift in the normalizer
            9, 10: b = {~a[63], a[62:0] ^ 63'($urandom % 1024 + 1)};
            // exponent gap above 53 where the small operand only reaches sticky
            11, 12: begin
                ea = 11'(200 + $urandom % 1800);
                eb = ea - 11'(54 + $urandom % 120);
                a  = {a[63], ea, a[51:0]};
                b  = {b[63], eb, b[51:0]};
            end
            13, 14: begin
                a = rand_small();
                b = rand_small();
            end
            // infinity against a finite or sometimes against a twin
            15: begin
                a = {a[63], 11'h7FF, 52'h0};
                if ($urandom % 4 == 0) begin
                    b = a;
                end
            end
            default: ;
        endcase
        if ($urandom % 2) begin
            tmp = a;
            a   = b;
            b   = tmp;
        end
    endtask

    // host double add rounds to nearest even
    function automatic logic [63:0] model_sum(input logic [63:0] a, input logic [63:0] b);
        real ra;
        real rb;
        ra = $bitstoreal(a);
        rb = $bitstoreal(b);
        return $realtobits(ra + rb);
    endfunction

    task automatic send_pair(input logic [63:0] a, input logic [63:0] b);
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        want_q.push_back(model_sum(a, b));
        opa_q.push_back(a);
        opb_q.push_back(b);
        sent_q.push_back(cycle);
    endtask

    //////////////////////////////
    // output checking
    //////////////////////////////
    // called once per falling edge before new inputs are driven
    task automatic check_output();
        logic [63:0] want;
        logic [63:0] opa;
        logic [63:0] opb;
        int unsigned sent_at;
        assert (!$isunknown(out_valid)) else begin
            err_timing++;
            $display("ERR %0t: out_valid is unknown", $time);
        end
        if (out_valid === 1'b1) begin
            assert (want_q.size() > 0) else begin
                err_timing++;
                $display("ERR %0t: out_valid with no pair in flight", $time);
            end
            if (want_q.size() > 0) begin
                want    = want_q.pop_front();
                opa     = opa_q.pop_front();
                opb     = opb_q.pop_front();
                sent_at = sent_q.pop_front();
                assert (cycle - sent_at == LATENCY) else begin
                    err_timing++;
                    $display("ERR %0t: result after %0d cycles, expected %0d",
                             $time, cycle - sent_at, LATENCY);
                end
                assert (result === want) else begin
                    err_value++;
                    $display("ERR %0t: %h + %h gave %h, expected %h",
                             $time, opa, opb, result, want);
                end
            end
        end else if (sent_q.size() > 0) begin
            // an overdue oldest pair is dropped so later ones still line up
            assert (cycle - sent_q[0] < LATENCY) else begin
                err_missing++;
                $display("ERR %0t: no result for the pair sent in cycle %0d",
                         $time, sent_q[0]);
                void'(want_q.pop_front());
                void'(opa_q.pop_front());
                void'(opb_q.pop_front());
                void'(sent_q.pop_front());
            end
        end
    endtask

    initial begin
        void'($urandom(32'h1b02));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_a        = '0;
        in_b        = '0;
        cycle       = 0;
        err_value   = 0;
        err_timing  = 0;
        err_missing = 0;
        sent        = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // first cycle out of reset
        @(negedge clk);
        cycle++;
        assert (out_valid === 1'b0) else begin
            err_timing++;
            $display("ERR %0t: out_valid high right after reset", $time);
        end
        assert (result === '0) else begin
            err_value++;
            $display("ERR %0t: result %h after reset, expected zero", $time, result);
        end

        // random traffic with about 70 percent of cycles carrying a pair
        while (sent < NUM_PAIRS) begin
            @(negedge clk);
            cycle++;
            check_output();
            if ($urandom % 10 < 7) begin
                make_pair(pair_a, pair_b);
                send_pair(pair_a, pair_b);
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end

        // drain
        wait_cnt = 0;
        while (want_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            cycle++;
            check_output();
            in_valid = 1'b0;
            wait_cnt++;
        end
        if (want_q.size() > 0) begin
            $display("timed out waiting for results, %0d still missing", want_q.size());
            err_missing += want_q.size();
        end

        // idle tail where any strobe is an extra result
        repeat (2 * LATENCY) begin
            @(negedge clk);
            cycle++;
            in_valid = 1'b0;
            check_output();
        end

        $display("errors: value %0d, timing %0d, missing %0d",
                 err_value, err_timing, err_missing);
        if (err_value + err_timing + err_missing == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/fp_add_pkg.sv
verilog/fp_stage_if.sv
verilog/fp_add_ctrl.sv
verilog/fp_align.sv
verilog/fp_mant_addsub.sv
verilog/fp_normalize.sv
verilog/fp_round.sv
verilog/fp_add_top.sv
verification/fp_add_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fp_add_tb
RTL_TOP   ?= fp_add_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
